// ==== ntm_exp_pkg.sv ====
/*
 * Arithmetic definitions for the vector exponential unit.
 * Holds the Q4.12 sample format, the Taylor reciprocal table and the
 * stream and write-port structs shared by the buffer and the vector unit.
 * Referenced by scoped names from the RTL.
 */
`default_nettype none

package ntm_exp_pkg;

  ////////////////////////////////////////
  // Fixed-point format
  ////////////////////////////////////////

  // Signed Q4.12 samples
  localparam int DATA_W = 16;
  localparam int FRAC_W = 12;
  localparam int ONE_FX = 4096;

  // Accumulator width for term and sum, wide enough for inputs in -2..2
  localparam int ACC_W = 32;

  // Max buffer index width carried on the source write port
  localparam int IDX_W = 8;

  ////////////////////////////////////////
  // Taylor series constants
  ////////////////////////////////////////

  localparam int MAX_TERMS = 12;

  // 4096/k rounded to nearest, k = 1..MAX_TERMS
  localparam int RECIP [1:MAX_TERMS] = '{
    4096, 2048, 1365, 1024, 819, 683,
    585, 512, 455, 410, 372, 341
  };

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic signed [DATA_W-1:0] sample_t;

  // Sample stream between buffer and vector unit
  typedef struct packed {
    logic    valid;
    sample_t sample;
  } stream_t;

  // Source memory write port
  typedef struct packed {
    logic             valid;
    logic [IDX_W-1:0] index;
    sample_t          sample;
  } src_write_t;

endpackage

`default_nettype wire

// ==== ntm_apb_pkg.sv ====
/*
 * APB bus definitions for the exponential unit register block.
 * Request and response structs plus the register map offsets.
 */
`default_nettype none

package ntm_apb_pkg;

  localparam int ADDR_W  = 12;
  localparam int PDATA_W = 32;

  // Word index bits inside one sample window (64 words per window)
  localparam int WIN_IDX_W = 6;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam logic [ADDR_W-1:0] CTRL_ADDR   = 12'h000;  // bit 0 starts a run
  localparam logic [ADDR_W-1:0] SIZE_ADDR   = 12'h004;
  localparam logic [ADDR_W-1:0] STATUS_ADDR = 12'h008;  // bit 0 BUSY, bit 1 DONE
  localparam logic [ADDR_W-1:0] SRC_BASE    = 12'h100;
  localparam logic [ADDR_W-1:0] RES_BASE    = 12'h200;

  typedef struct packed {
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [ADDR_W-1:0]  paddr;
    logic [PDATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [PDATA_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// ==== ntm_scalar_exponentiator.sv ====
/*
 * Scalar e^x in Q4.12 by a truncated Taylor series of TERMS terms.
 * One term per cycle; ready pulses exactly TERMS cycles after start,
 * with the 16-bit truncated sum on data_out.
 */
`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_exponentiator #(
  parameter int TERMS = 8
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  start,
  output logic                 ready,
  input  wire ntm_exp_pkg::sample_t data_in,
  output ntm_exp_pkg::sample_t data_out
);

  localparam int K_W   = $clog2(ntm_exp_pkg::MAX_TERMS + 1);
  localparam int ACC_W = ntm_exp_pkg::ACC_W;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Control
  logic           busy;
  logic [K_W-1:0] k;
  logic           last_step;

  // Datapath
  ntm_exp_pkg::sample_t    x_q;
  logic signed [ACC_W-1:0] term_q;
  logic signed [ACC_W-1:0] sum_q;
  logic signed [ACC_W-1:0] step_mul;
  logic signed [ACC_W-1:0] term_next;
  logic signed [ACC_W-1:0] sum_next;

  ////////////////////////////////////////
  // Next term
  ////////////////////////////////////////

  // term * x, then * 1/k, each rescaled by FRAC_W
  always_comb begin
    step_mul  = (term_q * x_q) >>> ntm_exp_pkg::FRAC_W;
    term_next = (step_mul * ntm_exp_pkg::RECIP[k]) >>> ntm_exp_pkg::FRAC_W;
    sum_next  = sum_q + term_next;
  end

  assign last_step = busy && (k == K_W'(TERMS - 1));

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      k     <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        k    <= K_W'(1);
      end else if (busy) begin
        k <= k + 1'b1;
        // Final term added this cycle
        if (last_step) begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start) begin
      x_q    <= data_in;
      term_q <= ACC_W'(ntm_exp_pkg::ONE_FX);
      sum_q  <= ACC_W'(ntm_exp_pkg::ONE_FX);
    end else if (busy) begin
      term_q <= term_next;
      sum_q  <= sum_next;
    end
    // Truncate to sample width on the way out
    if (last_step) begin
      data_out <= sum_next[ntm_exp_pkg::DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== ntm_exp_buffer.sv ====
/*
 * Source and result sample memories for the vector unit.
 * The read pointer answers data_in_request one cycle later, the write
 * pointer stores each data_out result. Result reads from the bus are
 * registered. Both pointers restart on start.
 */
`timescale 1ns/1ps
`default_nettype none

module ntm_exp_buffer #(
  parameter int DEPTH = 16
) (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            start,
  input  wire ntm_exp_pkg::src_write_t   src_wr,
  input  wire                            data_in_request,
  output ntm_exp_pkg::stream_t           data_in,
  input  wire ntm_exp_pkg::stream_t      data_out,
  input  wire                            res_rd_en,
  input  wire [$clog2(DEPTH)-1:0]        res_rd_index,
  output ntm_exp_pkg::sample_t           res_rd_data
);

  localparam int AW = $clog2(DEPTH);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  ntm_exp_pkg::sample_t src_mem [DEPTH];
  ntm_exp_pkg::sample_t res_mem [DEPTH];

  logic [AW-1:0]        rd_ptr;
  logic [AW-1:0]        wr_ptr;
  logic                 in_valid;
  ntm_exp_pkg::sample_t in_sample;

  assign data_in = '{valid: in_valid, sample: in_sample};

  // Pointers and response valid
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      in_valid <= 1'b0;
    end else begin
      in_valid <= data_in_request;
      if (start) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
      end else begin
        if (data_in_request) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        if (data_out.valid) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  // Memory ports
  always_ff @(posedge CLK) begin
    if (src_wr.valid) begin
      src_mem[src_wr.index[AW-1:0]] <= src_wr.sample;
    end
    if (data_in_request) begin
      in_sample <= src_mem[rd_ptr];
    end
    if (data_out.valid) begin
      res_mem[wr_ptr] <= data_out.sample;
    end
    // Bus side read, data one cycle after enable
    if (res_rd_en) begin
      res_rd_data <= res_mem[res_rd_index];
    end
  end

endmodule

`default_nettype wire

// ==== ntm_vector_exponentiator.sv ====
/*
 * Vector e^x control. Pulls size samples from the buffer one at a time,
 * runs each through the scalar unit and returns the result on data_out.
 * Pulses ready after the last element.
 */
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_exponentiator #(
  parameter int TERMS = 8,
  parameter int DEPTH = 16
) (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         start,
  output logic                        ready,
  input  wire [$clog2(DEPTH):0]       size,
  output logic                        data_in_request,
  input  wire ntm_exp_pkg::stream_t   data_in,
  output ntm_exp_pkg::stream_t        data_out
);

  localparam int SIZE_W = $clog2(DEPTH) + 1;

  typedef enum logic [1:0] {
    STARTER_STATE,
    INPUT_STATE,
    ENDER_STATE
  } state_t;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  state_t              state_q;
  logic [SIZE_W-1:0]   index_loop;
  logic [SIZE_W-1:0]   size_q;

  // Scalar unit handshake
  logic                 start_scalar;
  logic                 ready_scalar;
  ntm_exp_pkg::sample_t data_in_scalar;
  ntm_exp_pkg::sample_t data_out_scalar;

  // Result stream
  logic                 out_valid;
  ntm_exp_pkg::sample_t out_sample;

  // Request held until the buffer answers
  assign data_in_request = (state_q == INPUT_STATE) && !data_in.valid;
  assign data_out        = '{valid: out_valid, sample: out_sample};

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= STARTER_STATE;
      index_loop   <= '0;
      size_q       <= '0;
      ready        <= 1'b0;
      start_scalar <= 1'b0;
      out_valid    <= 1'b0;
    end else begin
      // Pulses by default low
      ready        <= 1'b0;
      start_scalar <= 1'b0;
      out_valid    <= 1'b0;
      case (state_q)
        STARTER_STATE: begin
          if (start) begin
            index_loop <= '0;
            size_q     <= size;
            state_q    <= INPUT_STATE;
          end
        end
        INPUT_STATE: begin
          // Every sample gets its own scalar start
          if (data_in.valid) begin
            start_scalar <= 1'b1;
            state_q      <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          if (ready_scalar) begin
            out_valid <= 1'b1;
            if (index_loop == size_q - 1'b1) begin
              ready   <= 1'b1;
              state_q <= STARTER_STATE;
            end else begin
              index_loop <= index_loop + 1'b1;
              state_q    <= INPUT_STATE;
            end
          end
        end
        default: begin
          state_q <= STARTER_STATE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Sample and result registers
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state_q == INPUT_STATE && data_in.valid) begin
      data_in_scalar <= data_in.sample;
    end
    if (state_q == ENDER_STATE && ready_scalar) begin
      out_sample <= data_out_scalar;
    end
  end

  ntm_scalar_exponentiator #(
    .TERMS(TERMS)
  ) u_scalar_exponentiator (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start_scalar),
    .ready   (ready_scalar),
    .data_in (data_in_scalar),
    .data_out(data_out_scalar)
  );

endmodule

`default_nettype wire

// ==== ntm_exp_apb_slave.sv ====
/*
 * APB register block of the exponential unit.
 * Decodes CTRL, SIZE, STATUS and the source and result windows, keeps
 * BUSY and DONE, and adds one wait state on result window reads.
 */
`timescale 1ns/1ps
`default_nettype none

module ntm_exp_apb_slave #(
  parameter int DEPTH = 16
) (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire ntm_apb_pkg::apb_req_t     apb_req,
  output ntm_apb_pkg::apb_rsp_t          apb_rsp,
  output logic                           start,
  output logic [$clog2(DEPTH):0]         size,
  input  wire                            ready,
  output ntm_exp_pkg::src_write_t        src_wr,
  output logic                           res_rd_en,
  output logic [$clog2(DEPTH)-1:0]       res_rd_index,
  input  wire ntm_exp_pkg::sample_t      res_rd_data
);

  localparam int AW     = $clog2(DEPTH);
  localparam int SIZE_W = AW + 1;
  localparam int WIN_W  = ntm_apb_pkg::WIN_IDX_W;
  localparam int ADDR_W = ntm_apb_pkg::ADDR_W;
  localparam int DW     = ntm_exp_pkg::DATA_W;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic access;
  logic ctrl_hit, size_hit, status_hit, src_hit, res_hit;
  logic map_err, idx_err, size_err, err;
  logic res_read, rd_wait, wr_en;

  logic [WIN_W-1:0]              win_idx;
  logic [ntm_exp_pkg::IDX_W-1:0] src_idx;

  // Registers
  logic [SIZE_W-1:0] size_q;
  logic              busy_q;
  logic              done_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign access  = apb_req.psel && apb_req.penable;
  assign win_idx = apb_req.paddr[WIN_W+1:2];
  assign src_idx = {{(ntm_exp_pkg::IDX_W - WIN_W){1'b0}}, win_idx};

  always_comb begin
    ctrl_hit   = (apb_req.paddr == ntm_apb_pkg::CTRL_ADDR);
    size_hit   = (apb_req.paddr == ntm_apb_pkg::SIZE_ADDR);
    status_hit = (apb_req.paddr == ntm_apb_pkg::STATUS_ADDR);
    // Windows are word aligned
    src_hit = (apb_req.paddr[ADDR_W-1:WIN_W+2] == ntm_apb_pkg::SRC_BASE[ADDR_W-1:WIN_W+2])
              && (apb_req.paddr[1:0] == 2'b00);
    res_hit = (apb_req.paddr[ADDR_W-1:WIN_W+2] == ntm_apb_pkg::RES_BASE[ADDR_W-1:WIN_W+2])
              && (apb_req.paddr[1:0] == 2'b00);

    // Error sources
    map_err  = !(ctrl_hit || size_hit || status_hit || src_hit || res_hit);
    idx_err  = (src_hit || res_hit) && (win_idx >= DEPTH);
    size_err = size_hit && apb_req.pwrite
               && (apb_req.pwdata == '0 || apb_req.pwdata > DEPTH);
    err      = map_err || idx_err || size_err;
  end

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Result reads wait one cycle for the registered memory
  assign res_read     = access && !apb_req.pwrite && res_hit && !idx_err;
  assign res_rd_en    = res_read && !rd_wait;
  assign res_rd_index = win_idx[AW-1:0];
  assign wr_en        = access && apb_req.pwrite && !err;

  always_comb begin
    apb_rsp.pready  = access && (!res_read || rd_wait);
    apb_rsp.pslverr = apb_rsp.pready && err;
    apb_rsp.prdata  = '0;
    if (size_hit) begin
      apb_rsp.prdata[SIZE_W-1:0] = size_q;
    end else if (status_hit) begin
      apb_rsp.prdata[1:0] = {done_q, busy_q};
    end else if (res_hit) begin
      apb_rsp.prdata[DW-1:0] = res_rd_data;
    end
  end

  // Source window writes go straight to the buffer
  assign src_wr = '{valid:  wr_en && src_hit,
                    index:  src_idx,
                    sample: apb_req.pwdata[DW-1:0]};

  assign size = size_q;

  ////////////////////////////////////////
  // Register state
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_wait <= 1'b0;
      size_q  <= SIZE_W'(DEPTH);
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      start   <= 1'b0;
    end else begin
      rd_wait <= res_read && !rd_wait;
      start   <= 1'b0;
      if (wr_en && size_hit) begin
        size_q <= apb_req.pwdata[SIZE_W-1:0];
      end
      // START while BUSY is dropped silently
      if (wr_en && ctrl_hit && apb_req.pwdata[0] && !busy_q) begin
        start  <= 1'b1;
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (ready) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== ntm_exp_top.sv ====
/*
 * Top of the APB vector exponential unit.
 * Sets TERMS and DEPTH and connects the register block, the sample
 * buffer and the vector unit.
 */
`timescale 1ns/1ps
`default_nettype none

module ntm_exp_top #(
  parameter int TERMS = 8,
  parameter int DEPTH = 16
) (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire ntm_apb_pkg::apb_req_t apb_req,
  output ntm_apb_pkg::apb_rsp_t      apb_rsp
);

  localparam int AW = $clog2(DEPTH);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  // Slave to vector unit
  logic          start;
  logic          ready;
  logic [AW:0]   size;

  // Slave to buffer
  ntm_exp_pkg::src_write_t src_wr;
  logic                    res_rd_en;
  logic [AW-1:0]           res_rd_index;
  ntm_exp_pkg::sample_t    res_rd_data;

  // Buffer to vector unit
  logic                 data_in_request;
  ntm_exp_pkg::stream_t data_in;
  ntm_exp_pkg::stream_t data_out;

  ntm_exp_apb_slave #(
    .DEPTH(DEPTH)
  ) u_apb_slave (
    .CLK         (CLK),
    .RST         (RST),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .start       (start),
    .size        (size),
    .ready       (ready),
    .src_wr      (src_wr),
    .res_rd_en   (res_rd_en),
    .res_rd_index(res_rd_index),
    .res_rd_data (res_rd_data)
  );

  ntm_exp_buffer #(
    .DEPTH(DEPTH)
  ) u_buffer (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .src_wr         (src_wr),
    .data_in_request(data_in_request),
    .data_in        (data_in),
    .data_out       (data_out),
    .res_rd_en      (res_rd_en),
    .res_rd_index   (res_rd_index),
    .res_rd_data    (res_rd_data)
  );

  ntm_vector_exponentiator #(
    .TERMS(TERMS),
    .DEPTH(DEPTH)
  ) u_vector_exponentiator (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .ready          (ready),
    .size           (size),
    .data_in_request(data_in_request),
    .data_in        (data_in),
    .data_out       (data_out)
  );

endmodule

`default_nettype wire

// ==== ntm_exp_tb_vectors.svh ====
/*
 * Test table for the exponential unit testbench.
 * Each entry holds a name, a vector length and DEPTH sample slots.
 * The expected slots are filled from the Taylor model when the table loads.
 */
`ifndef NTM_EXP_TB_VECTORS_SVH
`define NTM_EXP_TB_VECTORS_SVH

localparam int NUM_TESTS = 6;

string              test_name [NUM_TESTS];
int                 test_size [NUM_TESTS];
logic signed [15:0] test_x    [NUM_TESTS][DEPTH];
logic [15:0]        test_exp  [NUM_TESTS][DEPTH];

// Range ends and values around zero
localparam logic signed [15:0] EDGE_X [8] = '{
  -16'sd8192, 16'sd8192, -16'sd4096, 16'sd2048,
  -16'sd1, 16'sd1, 16'sd8191, -16'sd8191
};

task automatic load_tests();
  int t;
  int i;
  test_name[0] = "single_zero";
  test_size[0] = 1;
  test_name[1] = "single_one";
  test_size[1] = 1;
  test_name[2] = "full_random";
  test_size[2] = DEPTH;
  test_name[3] = "edge_values";
  test_size[3] = 8;
  // Short runs back to back over older results
  test_name[4] = "short_5";
  test_size[4] = 5;
  test_name[5] = "short_3";
  test_size[5] = 3;
  for (t = 0; t < NUM_TESTS; t++) begin
    for (i = 0; i < DEPTH; i++) begin
      test_x[t][i]   = '0;
      test_exp[t][i] = '0;
    end
  end
  test_x[0][0] = 16'sd0;
  test_x[1][0] = 16'sd4096;
  for (i = 0; i < 8; i++) begin
    test_x[3][i] = EDGE_X[i];
  end
  // Random samples limited to -2..2 in Q4.12
  for (i = 0; i < DEPTH; i++) begin
    test_x[2][i] = 16'(int'($urandom % 16385) - 8192);
    test_x[4][i] = 16'(int'($urandom % 16385) - 8192);
    test_x[5][i] = 16'(int'($urandom % 16385) - 8192);
  end
  for (t = 0; t < NUM_TESTS; t++) begin
    for (i = 0; i < test_size[t]; i++) begin
      test_exp[t][i] = exp_model(test_x[t][i]);
    end
  end
endtask

`endif

// ==== ntm_exp_tb.sv ====
/*
 * Testbench for the APB vector exponential unit.
 * Loads sample vectors over APB, starts runs, polls STATUS and compares
 * every result with a bit exact Taylor model. Also covers bus errors.
 */
`timescale 1ns/1ps
`default_nettype none

module ntm_exp_tb;

  localparam int TERMS = 8;
  localparam int DEPTH = 16;

  logic                  CLK;
  logic                  RST;
  ntm_apb_pkg::apb_req_t apb_req;
  ntm_apb_pkg::apb_rsp_t apb_rsp;

  int check_count = 0;
  int error_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  // Expected contents of the result memory across runs
  logic [15:0] res_model [DEPTH];
  bit          res_known [DEPTH];

  ////////////////////////////////////////
  // Model and table
  ////////////////////////////////////////

  // Truncated Taylor series with term k = ((prev * x) >>> 12) * (4096/k) >>> 12
  function automatic logic [15:0] exp_model(input logic signed [15:0] x);
    longint term;
    longint step;
    longint sum;
    longint recip;
    int     k;
    term = 4096;
    sum  = 4096;
    for (k = 1; k < TERMS; k++) begin
      recip = (4096 + k / 2) / k;
      step  = (term * x) >>> 12;
      term  = (step * recip) >>> 12;
      sum   = sum + term;
    end
    return sum[15:0];
  endfunction

  `include "ntm_exp_tb_vectors.svh"

  // Twice the run length plus APB traffic of all tests
  function automatic int cycle_budget();
    int total;
    int t;
    total = 150;
    for (t = 0; t < NUM_TESTS; t++) begin
      total += test_size[t] * (TERMS + 6) + DEPTH * 8 + 60;
    end
    return 2 * total;
  endfunction

  ntm_exp_top #(
    .TERMS(TERMS),
    .DEPTH(DEPTH)
  ) u_ntm_exp_top (
    .CLK    (CLK),
    .RST    (RST),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Bus and check tasks
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Setup then access phase with the response sampled at the falling edge
  task automatic bus_transfer(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(posedge CLK);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge CLK);
    apb_req.penable <= 1'b1;
    @(negedge CLK);
    while (!apb_rsp.pready) begin
      @(posedge CLK);
      @(negedge CLK);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge CLK);
    apb_req <= '0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] wdata,
                           output logic err);
    logic [31:0] unused;
    bus_transfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] rdata,
                          output logic err);
    bus_transfer(1'b0, addr, 32'h0, rdata, err);
  endtask

  ////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////

  task automatic run_test(input int t);
    logic [31:0] rdata;
    logic        err;
    int          n;
    int          i;
    int          polls;
    bit          done_seen;
    n = test_size[t];
    // Whole window loaded so a run past SIZE would change later results
    for (i = 0; i < DEPTH; i++) begin
      write_reg(ntm_apb_pkg::SRC_BASE + 12'(4 * i), 32'(test_x[t][i]), err);
      check_value({test_name[t], " source write error"}, 32'h0, 32'(err));
    end
    write_reg(ntm_apb_pkg::SIZE_ADDR, 32'(n), err);
    check_value({test_name[t], " size write error"}, 32'h0, 32'(err));
    write_reg(ntm_apb_pkg::CTRL_ADDR, 32'h1, err);
    check_value({test_name[t], " start write error"}, 32'h0, 32'(err));
    read_reg(ntm_apb_pkg::STATUS_ADDR, rdata, err);
    check_value({test_name[t], " status after start"}, 32'h1, rdata);
    // Second start while busy is dropped
    write_reg(ntm_apb_pkg::CTRL_ADDR, 32'h1, err);
    check_value({test_name[t], " start while busy error"}, 32'h0, 32'(err));
    done_seen = 1'b0;
    polls     = 0;
    while (!done_seen && polls < n * (TERMS + 6) + 10) begin
      read_reg(ntm_apb_pkg::STATUS_ADDR, rdata, err);
      done_seen = rdata[1];
      polls++;
    end
    if (!done_seen) begin
      error_count++;
      $display("%s: DONE never set after %0d status polls", test_name[t], polls);
    end else begin
      check_value({test_name[t], " status at end"}, 32'h2, rdata);
    end
    for (i = 0; i < n; i++) begin
      res_model[i] = test_exp[t][i];
      res_known[i] = 1'b1;
    end
    // Slots past SIZE keep results of earlier runs
    for (i = 0; i < DEPTH; i++) begin
      if (res_known[i]) begin
        read_reg(ntm_apb_pkg::RES_BASE + 12'(4 * i), rdata, err);
        check_value($sformatf("%s result[%0d]", test_name[t], i), {16'h0, res_model[i]},
                    rdata);
      end
    end
  endtask

  task automatic check_errors();
    logic [31:0] rdata;
    logic        err;
    logic [11:0] bad_addr [4];
    logic [31:0] bad_data [4];
    string       bad_name [4];
    int          i;
    bad_addr[0] = 12'h00C;
    bad_data[0] = 32'h5;
    bad_name[0] = "unmapped address";
    bad_addr[1] = ntm_apb_pkg::SRC_BASE + 12'(4 * DEPTH);
    bad_data[1] = 32'h1234;
    bad_name[1] = "source index DEPTH";
    bad_addr[2] = ntm_apb_pkg::SIZE_ADDR;
    bad_data[2] = 32'h0;
    bad_name[2] = "size zero";
    bad_addr[3] = ntm_apb_pkg::SIZE_ADDR;
    bad_data[3] = 32'(DEPTH + 1);
    bad_name[3] = "size above DEPTH";
    write_reg(ntm_apb_pkg::SIZE_ADDR, 32'h7, err);
    check_value("error setup size write", 32'h0, 32'(err));
    for (i = 0; i < 4; i++) begin
      write_reg(bad_addr[i], bad_data[i], err);
      check_value({bad_name[i], " pslverr"}, 32'h1, 32'(err));
      read_reg(ntm_apb_pkg::SIZE_ADDR, rdata, err);
      check_value({bad_name[i], " size readback"}, 32'h7, rdata);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int t;
    RST     = 1'b1;
    apb_req = '0;
    for (t = 0; t < DEPTH; t++) begin
      res_known[t] = 1'b0;
    end
    void'($urandom(45));
    load_tests();
    cycle_limit = cycle_budget();
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    check_errors();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Run limit from the test lengths
  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
ntm_exp_pkg.sv
ntm_apb_pkg.sv
ntm_scalar_exponentiator.sv
ntm_exp_buffer.sv
ntm_vector_exponentiator.sv
ntm_exp_apb_slave.sv
ntm_exp_top.sv
ntm_exp_tb.sv
